// File: Makefile
# Verilator build and run of the pwm pair testbench.
TOP := tb_pwm_pair

.PHONY: all lint clean

# build, run, then search the log for the failure line.
all:
	verilator --binary --timing --assert --top-module $(TOP) -f pwm_pair.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Checks failed" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f pwm_pair.f

clean:
	rm -rf obj_dir sim.log

// File: cdpwm.sv
`timescale 1ns/1ps

// one countdown pwm channel.
// the reload value is fixed when the design is built, only the duty is
// loaded by software.
// the live counter value is visible on the bus so that software can line up
// with the period, which also makes the channel usable as a plain timer.
// the output is registered so that no comparator glitch reaches a pin.
// a duty change in the middle of a period takes effect at once, so software
// should load it right after a reload while the output is low.
// duty zero keeps the output low, duty start plus one keeps it high.
module cdpwm import pwm_pkg::*; #(
    parameter int width = 16,
    parameter int start = 9
) (
    input  logic                  sysclk,
    input  logic                  sysreset,
    input  logic                  counter_tick,
    output logic [word_width-1:0] counter_value,
    output logic [word_width-1:0] duty,
    input  logic                  duty_load,
    input  logic [word_width-1:0] data_in,
    output logic                  pwm_signal
);

    // reload value trimmed to the counter width.
    localparam logic [width-1:0] start_value = start[width-1:0];

    logic             tick_last;
    logic             tick_edge;
    logic [width-1:0] cnt;
    logic [width-1:0] duty_q;
    logic             pwm_comb;
    logic             pwm_reg;

    // the previous tick level is kept so that a tick held high counts once.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            tick_last <= 1'b0;
        end else begin
            tick_last <= counter_tick;
        end
    end

    assign tick_edge = counter_tick && !tick_last;

    // the down counter steps on the same edge that samples the tick rising.
    // after reaching zero it reloads the start value on the next tick.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            cnt <= start_value;
        end else if (tick_edge) begin
            if (cnt == '0) begin
                cnt <= start_value;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // duty register keeps only the low bits of the bus word.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            duty_q <= '0;
        end else if (duty_load) begin
            duty_q <= data_in[width-1:0];
        end
    end

    // output is high while the counter sits below the duty.
    assign pwm_comb = cnt < duty_q;

    // one cycle of delay between a counter change and the channel output.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            pwm_reg <= 1'b0;
        end else begin
            pwm_reg <= pwm_comb;
        end
    end

    // narrow channels read back with zeros above their width.
    assign counter_value = word_width'(cnt);
    assign duty          = word_width'(duty_q);
    assign pwm_signal    = pwm_reg;

    // the reload path is the only way into the counter above zero.
    a_cnt_in_range: assert property (
        @(posedge sysclk) disable iff (sysreset)
        cnt <= start_value
    ) else $error("cdpwm counter above its start value");

    // a zero duty must give a low output on the following cycle.
    a_zero_duty_low: assert property (
        @(posedge sysclk) disable iff (sysreset)
        (duty_q == '0) |=> !pwm_signal
    ) else $error("cdpwm output high with zero duty");

endmodule

// File: pwm_bus_regs.sv
`timescale 1ns/1ps

// register block of the pwm pair.
// writes are a single strobe with no handshake and always complete.
// reads are combinational from the address, there is no read strobe.
module pwm_bus_regs import pwm_pkg::*; (
    input  logic                  sysclk,
    input  logic                  sysreset,
    input  reg_addr_e             bus_addr,
    input  logic [word_width-1:0] bus_wdata,
    input  logic                  bus_write,
    output logic [word_width-1:0] bus_rdata,
    output logic                  duty_load0,
    output logic                  duty_load1,
    output logic [word_width-1:0] data_in,
    output combine_mode_e         mode,
    input  logic [word_width-1:0] duty0,
    input  logic [word_width-1:0] duty1,
    input  logic [word_width-1:0] count0,
    input  logic [word_width-1:0] count1
);

    logic          mode_write;
    combine_mode_e mode_q;

    // the duty registers live in the channels.
    // this block only turns a write into a load pulse for the right one.
    // the pulse lasts as long as the write strobe, which is one cycle.
    assign duty_load0 = bus_write && (bus_addr == REG_DUTY0);
    assign duty_load1 = bus_write && (bus_addr == REG_DUTY1);

    // both channels see the write data, the load pulse picks the target.
    assign data_in = bus_wdata;

    assign mode_write = bus_write && (bus_addr == REG_MODE);

    // the mode register keeps only the low bits of the word.
    // codes outside the enum are stored as they are, the combiner maps them
    // onto the independent mode.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            mode_q <= MODE_INDEPENDENT;
        end else if (mode_write) begin
            mode_q <= combine_mode_e'(bus_wdata[mode_width-1:0]);
        end
    end

    assign mode = mode_q;

    // readback multiplexer.
    // a register that was written at the last edge already shows its new value.
    always_comb begin
        case (bus_addr)
            REG_DUTY0: begin
                bus_rdata = duty0;
            end
            REG_DUTY1: begin
                bus_rdata = duty1;
            end
            REG_MODE: begin
                bus_rdata = word_width'(mode_q);
            end
            REG_CNT0: begin
                bus_rdata = count0;
            end
            REG_CNT1: begin
                bus_rdata = count1;
            end
            default: begin
                // unused codes read as zero.
                bus_rdata = '0;
            end
        endcase
    end

    // one write must never load both channels.
    a_one_load: assert property (
        @(posedge sysclk) disable iff (sysreset)
        !(duty_load0 && duty_load1)
    ) else $error("both duty load pulses high together");

endmodule

// File: pwm_checker.sv
`timescale 1ns/1ps

// checking module of the pwm pair testbench.
// it builds its own picture of the peripheral from the tick and bus inputs
// and compares read data and both pins at every falling clock edge.
// a counter change reaches the channel level one edge later and the pins
// one edge after that, as the top level timing describes.
module pwm_checker import pwm_pkg::*; (
    input  logic                  sysclk,
    input  logic                  sysreset,
    input  logic                  counter_tick,
    input  logic [addr_width-1:0] bus_addr,
    input  logic [word_width-1:0] bus_wdata,
    input  logic                  bus_write,
    input  logic [word_width-1:0] bus_rdata,
    input  logic                  pwm_out_a,
    input  logic                  pwm_out_b,
    output int                    error_count
);

    logic                  tick_q;
    logic [ch0_width-1:0]  cnt0;
    logic [ch1_width-1:0]  cnt1;
    logic [ch0_width-1:0]  duty0;
    logic [ch1_width-1:0]  duty1;
    logic [mode_width-1:0] mode;
    logic                  sig_a;
    logic                  sig_b;
    logic                  pin_a;
    logic                  pin_b;
    logic [1:0]            pins_next;
    int                    errors = 0;

    // pin levels packed as {a, b} for a mode and the two channel levels.
    // the combining modes put the inverse of pin a on pin b.
    function automatic logic [1:0] pin_rule(input logic [mode_width-1:0] m,
                                            input logic a, input logic b);
        logic [1:0] r;
        case (m)
            MODE_AND: r = {a & b, ~(a & b)};
            MODE_OR: r = {a | b, ~(a | b)};
            MODE_XOR: r = {a ^ b, ~(a ^ b)};
            MODE_COMPLEMENT: r = {a, ~a};
            default: r = {a, b};
        endcase
        return r;
    endfunction

    // value the bus should show for an address, narrow storage zero-extended.
    function automatic logic [word_width-1:0] expected_read(input logic [addr_width-1:0] a);
        logic [word_width-1:0] r;
        case (a)
            REG_DUTY0: r = word_width'(duty0);
            REG_DUTY1: r = word_width'(duty1);
            REG_MODE: r = word_width'(mode);
            REG_CNT0: r = word_width'(cnt0);
            REG_CNT1: r = word_width'(cnt1);
            default: r = '0;
        endcase
        return r;
    endfunction

    assign pins_next = pin_rule(mode, sig_a, sig_b);

    always @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            tick_q <= 1'b0;
            cnt0   <= ch0_width'(ch0_start);
            cnt1   <= ch1_width'(ch1_start);
            duty0  <= '0;
            duty1  <= '0;
            mode   <= MODE_INDEPENDENT;
            sig_a  <= 1'b0;
            sig_b  <= 1'b0;
            pin_a  <= 1'b0;
            pin_b  <= 1'b0;
        end else begin
            tick_q <= counter_tick;
            // a counter that was zero takes its start value again.
            if (counter_tick && !tick_q) begin
                cnt0 <= (cnt0 == '0) ? ch0_width'(ch0_start) : cnt0 - 1'b1;
                cnt1 <= (cnt1 == '0) ? ch1_width'(ch1_start) : cnt1 - 1'b1;
            end
            if (bus_write && bus_addr == REG_DUTY0) begin
                duty0 <= bus_wdata[ch0_width-1:0];
            end
            if (bus_write && bus_addr == REG_DUTY1) begin
                duty1 <= bus_wdata[ch1_width-1:0];
            end
            if (bus_write && bus_addr == REG_MODE) begin
                mode <= bus_wdata[mode_width-1:0];
            end
            sig_a <= cnt0 < duty0;
            sig_b <= cnt1 < duty1;
            pin_a <= pins_next[1];
            pin_b <= pins_next[0];
        end
    end

    // halfway through the cycle all inputs and registers have settled.
    always @(negedge sysclk) begin
        if (bus_rdata !== expected_read(bus_addr)) begin
            errors = errors + 1;
            $display("ERROR at time %0t: read of address %0d gave %h, model expects %h",
                     $time, bus_addr, bus_rdata, expected_read(bus_addr));
        end
        if (pwm_out_a !== pin_a || pwm_out_b !== pin_b) begin
            errors = errors + 1;
            $display("ERROR at time %0t: pins a b are %b %b, model expects %b %b in mode %0d",
                     $time, pwm_out_a, pwm_out_b, pin_a, pin_b, mode);
        end
    end

    assign error_count = errors;

endmodule

// File: pwm_combiner.sv
`timescale 1ns/1ps

// maps the two channel signals onto the two output pins.
// both pins are registered, so a mode change shows one cycle after the write
// and a channel change one cycle after the channel output.
// in the combining modes pin b is always the inverse of pin a, which gives a
// complementary pair for driving a half bridge.
module pwm_combiner import pwm_pkg::*; (
    input  logic          sysclk,
    input  logic          sysreset,
    input  combine_mode_e mode,
    input  logic          pwm_a,
    input  logic          pwm_b,
    output logic          pwm_out_a,
    output logic          pwm_out_b
);

    logic next_a;
    logic next_b;

    // pin values for the next cycle.
    always_comb begin
        case (mode)
            MODE_AND: begin
                next_a = pwm_a & pwm_b;
                next_b = ~(pwm_a & pwm_b);
            end
            MODE_OR: begin
                next_a = pwm_a | pwm_b;
                next_b = ~(pwm_a | pwm_b);
            end
            MODE_XOR: begin
                next_a = pwm_a ^ pwm_b;
                next_b = ~(pwm_a ^ pwm_b);
            end
            MODE_COMPLEMENT: begin
                // channel b is ignored here.
                next_a = pwm_a;
                next_b = ~pwm_a;
            end
            default: begin
                // the unused codes also take the independent mode.
                next_a = pwm_a;
                next_b = pwm_b;
            end
        endcase
    end

    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            pwm_out_a <= 1'b0;
            pwm_out_b <= 1'b0;
        end else begin
            pwm_out_a <= next_a;
            pwm_out_b <= next_b;
        end
    end

    // in a combining mode the pins after the next edge form a true pair.
    a_pins_differ: assert property (
        @(posedge sysclk) disable iff (sysreset)
        (mode inside {MODE_AND, MODE_OR, MODE_XOR, MODE_COMPLEMENT})
            |=> (pwm_out_a != pwm_out_b)
    ) else $error("combiner pins equal outside independent mode");

endmodule

// File: pwm_pair.f
pwm_pkg.sv
cdpwm.sv
pwm_bus_regs.sv
pwm_combiner.sv
pwm_pair_top.sv
pwm_checker.sv
tb_pwm_pair.sv

// File: pwm_pair_top.sv
`timescale 1ns/1ps

// top level of the pwm pair peripheral.
// two countdown channels share one tick, a register block loads their
// duties and the mode, and a combiner drives the two pins.
// from a tick rising edge to the pins there are two cycles of delay, one in
// the channel output register and one in the combiner.
module pwm_pair_top import pwm_pkg::*; (
    input  logic                  sysclk,
    input  logic                  sysreset,
    input  logic                  counter_tick,
    input  reg_addr_e             bus_addr,
    input  logic [word_width-1:0] bus_wdata,
    input  logic                  bus_write,
    output logic [word_width-1:0] bus_rdata,
    output logic                  pwm_out_a,
    output logic                  pwm_out_b
);

    logic                  duty_load0;
    logic                  duty_load1;
    logic [word_width-1:0] data_in;
    combine_mode_e         mode;
    logic [word_width-1:0] duty0;
    logic [word_width-1:0] duty1;
    logic [word_width-1:0] count0;
    logic [word_width-1:0] count1;
    logic                  pwm_a;
    logic                  pwm_b;

    pwm_bus_regs i_regs (
        .sysclk     (sysclk),
        .sysreset   (sysreset),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_write  (bus_write),
        .bus_rdata  (bus_rdata),
        .duty_load0 (duty_load0),
        .duty_load1 (duty_load1),
        .data_in    (data_in),
        .mode       (mode),
        .duty0      (duty0),
        .duty1      (duty1),
        .count0     (count0),
        .count1     (count1)
    );

    // channel 0 runs a full word wide.
    cdpwm #(
        .width (ch0_width),
        .start (ch0_start)
    ) i_ch0 (
        .sysclk        (sysclk),
        .sysreset      (sysreset),
        .counter_tick  (counter_tick),
        .counter_value (count0),
        .duty          (duty0),
        .duty_load     (duty_load0),
        .data_in       (data_in),
        .pwm_signal    (pwm_a)
    );

    // channel 1 is narrow and keeps only the low byte of a duty write.
    cdpwm #(
        .width (ch1_width),
        .start (ch1_start)
    ) i_ch1 (
        .sysclk        (sysclk),
        .sysreset      (sysreset),
        .counter_tick  (counter_tick),
        .counter_value (count1),
        .duty          (duty1),
        .duty_load     (duty_load1),
        .data_in       (data_in),
        .pwm_signal    (pwm_b)
    );

    pwm_combiner i_comb (
        .sysclk    (sysclk),
        .sysreset  (sysreset),
        .mode      (mode),
        .pwm_a     (pwm_a),
        .pwm_b     (pwm_b),
        .pwm_out_a (pwm_out_a),
        .pwm_out_b (pwm_out_b)
    );

endmodule

// File: pwm_pkg.sv
// shared widths, reset values and encodings for the pwm pair peripheral.
package pwm_pkg;

    // width of the register bus data path.
    localparam int word_width = 16;

    // width of the register bus address.
    localparam int addr_width = 3;

    // width of the combine mode field held in the mode register.
    localparam int mode_width = 3;

    // channel 0 uses a full word for its counter and duty.
    localparam int ch0_width = 16;

    // channel 1 is narrower than a word, so its readback is zero-extended.
    localparam int ch1_width = 8;

    // reload value of channel 0.
    // a period is start plus one ticks long, so this gives ten ticks.
    localparam int ch0_start = 9;

    // channel 1 reloads to this value and so has fifteen ticks per period.
    localparam int ch1_start = 14;

    // register map of the bus.
    // codes not listed here read as zero and ignore writes.
    typedef enum logic [addr_width-1:0] {
        REG_DUTY0 = 3'd0,
        REG_DUTY1 = 3'd1,
        REG_MODE  = 3'd2,
        REG_CNT0  = 3'd3,
        REG_CNT1  = 3'd4
    } reg_addr_e;

    // how the combiner maps the two channel signals onto the two pins.
    // the codes not listed here behave like the independent mode.
    typedef enum logic [mode_width-1:0] {
        MODE_INDEPENDENT = 3'd0,
        MODE_AND         = 3'd1,
        MODE_OR          = 3'd2,
        MODE_XOR         = 3'd3,
        MODE_COMPLEMENT  = 3'd4
    } combine_mode_e;

endpackage

// File: tb_pwm_pair.sv
`timescale 1ns/1ps

// testbench top of the pwm pair.
// random ticks and bus traffic go into the DUT, and the checker next to it
// compares every cycle against its own model.
module tb_pwm_pair import pwm_pkg::*; ();

    logic                  sysclk = 1'b0;
    logic                  sysreset;
    logic                  counter_tick;
    reg_addr_e             bus_addr;
    logic [word_width-1:0] bus_wdata;
    logic                  bus_write;
    logic [word_width-1:0] bus_rdata;
    logic                  pwm_out_a;
    logic                  pwm_out_b;
    int                    error_count;
    int                    tests_failed = 0;
    int                    timeouts = 0;
    int                    test_number = 0;
    int                    errors_at_start = 0;
    int                    timeouts_at_start = 0;

    always #10 sysclk = ~sysclk;

    pwm_pair_top i_dut (
        .sysclk       (sysclk),
        .sysreset     (sysreset),
        .counter_tick (counter_tick),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_write    (bus_write),
        .bus_rdata    (bus_rdata),
        .pwm_out_a    (pwm_out_a),
        .pwm_out_b    (pwm_out_b)
    );

    pwm_checker i_check (
        .sysclk       (sysclk),
        .sysreset     (sysreset),
        .counter_tick (counter_tick),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_write    (bus_write),
        .bus_rdata    (bus_rdata),
        .pwm_out_a    (pwm_out_a),
        .pwm_out_b    (pwm_out_b),
        .error_count  (error_count)
    );

    // inputs change 2 ns after the rising edge, and a write lasts one edge.
    task automatic cycle();
        @(posedge sysclk);
        #2;
        bus_write = 1'b0;
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [word_width-1:0] data);
        bus_addr  = addr;
        bus_wdata = data;
        bus_write = 1'b1;
        cycle();
    endtask

    task automatic read_reg(input reg_addr_e addr);
        bus_addr = addr;
        cycle();
    endtask

    task automatic read_all();
        for (int a = 0; a < 8; a++) begin
            read_reg(reg_addr_e'(a[addr_width-1:0]));
        end
    endtask

    function automatic reg_addr_e random_addr(input bit counters_only);
        reg_addr_e r;
        if (counters_only) begin
            r = ($urandom_range(0, 1) == 0) ? REG_CNT0 : REG_CNT1;
        end else begin
            r = reg_addr_e'(addr_width'($urandom_range(0, 7)));
        end
        return r;
    endfunction

    // a single tick with a random read in every cycle.
    task automatic tick_pulse(input int high_len, input int low_len, input bit counters_only);
        counter_tick = 1'b1;
        for (int i = 0; i < high_len; i++) begin
            read_reg(random_addr(counters_only));
        end
        counter_tick = 1'b0;
        for (int i = 0; i < low_len; i++) begin
            read_reg(random_addr(counters_only));
        end
    endtask

    task automatic random_ticks(input int count, input bit counters_only);
        int high_len;
        for (int i = 0; i < count; i++) begin
            // about one tick in four stays high for a long stretch.
            high_len = ($urandom_range(0, 3) == 0) ? $urandom_range(8, 16) : $urandom_range(1, 3);
            tick_pulse(high_len, $urandom_range(1, 3), counters_only);
        end
    endtask

    // ticks until channel 0 reads zero, giving a known phase in the period.
    task automatic wait_count_zero();
        bit found;
        found = 1'b0;
        for (int i = 0; i < 4 * (ch0_start + 1) && !found; i++) begin
            bus_addr     = REG_CNT0;
            counter_tick = ~counter_tick;
            cycle();
            found = (bus_rdata == '0);
        end
        counter_tick = 1'b0;
        if (!found) begin
            $display("timeout: channel 0 counter never read zero while ticking");
            timeouts++;
        end
    endtask

    task automatic apply_reset();
        sysreset = 1'b1;
        repeat (4) cycle();
        sysreset = 1'b0;
    endtask

    task automatic begin_test();
        test_number++;
        errors_at_start   = error_count;
        timeouts_at_start = timeouts;
    endtask

    task automatic end_test(input string name);
        int problems;
        problems = error_count - errors_at_start + timeouts - timeouts_at_start;
        if (problems != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d problems", test_number, name,
                 (problems == 0) ? "ok" : "failed", problems);
    endtask

    initial begin
        int                    d0;
        int                    d1;
        logic [word_width-1:0] word;
        void'($urandom(59));
        sysreset     = 1'b1;
        counter_tick = 1'b0;
        bus_addr     = REG_DUTY0;
        bus_wdata    = '0;
        bus_write    = 1'b0;

        begin_test();
        apply_reset();
        read_all();
        end_test("reset values");

        // random writes and reads also cover the unused codes.
        begin_test();
        for (int i = 0; i < 40; i++) begin
            if ($urandom_range(0, 1) == 0) begin
                write_reg(random_addr(1'b0), word_width'($urandom));
            end else begin
                read_reg(random_addr(1'b0));
            end
        end
        write_reg(REG_DUTY1, 16'hA5C3);
        read_all();
        end_test("register readback");

        begin_test();
        random_ticks(30, 1'b1);
        wait_count_zero();
        random_ticks(4, 1'b1);
        end_test("counting and reload");

        // the first two rounds use the ends of the duty range.
        begin_test();
        write_reg(REG_MODE, word_width'(MODE_INDEPENDENT));
        for (int k = 0; k < 5; k++) begin
            if (k == 0) begin
                d0 = 0;
                d1 = 0;
            end else if (k == 1) begin
                d0 = ch0_start + 1;
                d1 = ch1_start + 1;
            end else begin
                d0 = $urandom_range(0, ch0_start + 1);
                d1 = $urandom_range(0, ch1_start + 1);
            end
            wait_count_zero();
            write_reg(REG_DUTY0, word_width'(d0));
            write_reg(REG_DUTY1, word_width'(d1));
            random_ticks(20, 1'b0);
        end
        end_test("independent pins");

        // combining modes in turn with random upper bits in the mode word.
        begin_test();
        for (int k = 0; k < 16; k++) begin
            write_reg(REG_DUTY0, word_width'($urandom_range(0, ch0_start + 1)));
            write_reg(REG_DUTY1, word_width'($urandom_range(0, ch1_start + 1)));
            word = word_width'($urandom);
            word[mode_width-1:0] = mode_width'(1 + k % 4);
            write_reg(REG_MODE, word);
            random_ticks(6, 1'b0);
        end
        end_test("combine modes");

        // reset lands while a tick is high.
        begin_test();
        random_ticks(5, 1'b0);
        counter_tick = 1'b1;
        apply_reset();
        counter_tick = 1'b0;
        read_all();
        end_test("reset mid-run");

        cycle();
        $display("summary: %0d tests, %0d failed, %0d checker errors, %0d timeouts",
                 test_number, tests_failed, error_count, timeouts);
        if (tests_failed == 0 && error_count == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
